// File: hw/oculink_pkg.sv
package oculink_pkg;

  // --------------------
  // Beat layout
  // --------------------
  localparam int DATA_WIDTH     = 128;
  localparam int DWORD_WIDTH    = 32;
  localparam int ADDR_WIDTH     = 64;
  localparam int TAG_WIDTH      = 8;
  localparam int TYPE_WIDTH     = 4;
  localparam int STATUS_WIDTH   = 3;
  localparam int CFG_OFF_WIDTH  = 12;
  localparam int QPTR_WIDTH     = 16;

  localparam int RQ_DATA_LSB    = 0;   // Payload dword
  localparam int RQ_ADDR_LSB    = 32;
  localparam int RQ_TAG_LSB     = 96;
  localparam int RQ_TYPE_LSB    = 104;
  localparam int CPL_TAG_LSB    = 32;
  localparam int CPL_STATUS_LSB = 40;

  // --------------------
  // Endpoint addressing
  // --------------------
  localparam logic [15:0]           TARGET_ID = 16'h0100;  // Bus 1, dev 0, fn 0
  localparam logic [ADDR_WIDTH-1:0] DB_BASE   = 64'hF000_1000;  // SQ0 tail
  localparam logic [ADDR_WIDTH-1:0] DB_STRIDE = 64'd4;

  typedef enum logic [TYPE_WIDTH-1:0] {
    REQ_MEM_WRITE  = 4'd0,
    REQ_CFG_WRITE0 = 4'd1
  } req_type_e;

  typedef enum logic [STATUS_WIDTH-1:0] {
    CPL_SC = 3'd0,
    CPL_UR = 3'd1,
    CPL_CA = 3'd4
  } cpl_status_e;

  typedef enum logic [1:0] {CTL_WAIT_LINK, CTL_CONFIG, CTL_READY, CTL_FAILED} ctl_state_e;
  typedef enum logic [1:0] {CFG_IDLE, CFG_SEND, CFG_WAIT_CPL} cfg_state_e;

  // Single-beat request, unused upper bits left zero
  function automatic logic [DATA_WIDTH-1:0] make_rq(input req_type_e rtype,
                                                    input logic [TAG_WIDTH-1:0] tag,
                                                    input logic [ADDR_WIDTH-1:0] addr,
                                                    input logic [DWORD_WIDTH-1:0] data);
    logic [DATA_WIDTH-1:0] beat;
    beat = '0;
    beat[RQ_DATA_LSB +: DWORD_WIDTH] = data;
    beat[RQ_ADDR_LSB +: ADDR_WIDTH]  = addr;
    beat[RQ_TAG_LSB +: TAG_WIDTH]    = tag;
    beat[RQ_TYPE_LSB +: TYPE_WIDTH]  = rtype;
    return beat;
  endfunction

endpackage

// File: hw/config_rom.sv
`timescale 1ns/1ps

module config_rom
  import oculink_pkg::*;
#(
  parameter int ROM_ENTRIES    = 4,
  parameter int ROM_ADDR_WIDTH = 6
) (
  input  logic [ROM_ADDR_WIDTH-1:0] rom_addr,
  output logic [CFG_OFF_WIDTH-1:0]  rom_offset,
  output logic [DWORD_WIDTH-1:0]    rom_data
);

  logic in_range;

  assign in_range = (rom_addr < ROM_ADDR_WIDTH'(ROM_ENTRIES));

  always_comb begin
    rom_offset = '0;
    rom_data   = '0;
    if (in_range) begin
      case (rom_addr)
        'd0: begin rom_offset = 12'h010; rom_data = 32'hF000_0000; end  // BAR0 low
        'd1: begin rom_offset = 12'h014; rom_data = 32'h0000_0000; end  // BAR0 high
        'd2: begin rom_offset = 12'h004; rom_data = 32'h0000_0006; end  // Mem space + bus master
        'd3: begin rom_offset = 12'h03C; rom_data = 32'h0000_01FF; end  // Interrupt line/pin
        default: begin
          rom_offset = '0;
          rom_data   = '0;
        end
      endcase
    end
  end

endmodule

// File: hw/configurator.sv
`timescale 1ns/1ps

module configurator
  import oculink_pkg::*;
#(
  parameter int ROM_ENTRIES    = 4,
  parameter int ROM_ADDR_WIDTH = 6
) (
  input  logic                      user_clk,
  input  logic                      user_reset,
  input  logic                      start_config,
  output logic                      cfg_done,
  output logic                      cfg_error,
  output logic [ROM_ADDR_WIDTH-1:0] rom_addr,
  input  logic [CFG_OFF_WIDTH-1:0]  rom_offset,
  input  logic [DWORD_WIDTH-1:0]    rom_data,
  output logic [DATA_WIDTH-1:0]     cfg_rq_tdata,
  output logic                      cfg_rq_tvalid,
  input  logic                      cfg_rq_tready,
  input  logic [DATA_WIDTH-1:0]     rc_tdata,
  input  logic                      rc_tvalid,
  output logic                      rc_tready
);

  cfg_state_e                state;
  logic [ROM_ADDR_WIDTH-1:0] entry;      // Also the request tag
  logic [ADDR_WIDTH-1:0]     cfg_addr;
  logic [TAG_WIDTH-1:0]      cpl_tag;
  cpl_status_e               cpl_status;
  logic                      tag_hit;
  logic                      last_entry;

  assign rom_addr = entry;

  // --------------------
  // Request beat
  // --------------------
  // Target ID in 31:16, register offset below it
  assign cfg_addr = {{(ADDR_WIDTH - 32){1'b0}}, TARGET_ID,
                     {(16 - CFG_OFF_WIDTH){1'b0}}, rom_offset};

  assign cfg_rq_tvalid = (state == CFG_SEND);
  assign cfg_rq_tdata  = make_rq(REQ_CFG_WRITE0, TAG_WIDTH'(entry), cfg_addr, rom_data);

  // --------------------
  // Completion matching
  // --------------------
  assign rc_tready  = (state == CFG_WAIT_CPL);
  assign cpl_tag    = rc_tdata[CPL_TAG_LSB +: TAG_WIDTH];
  assign cpl_status = cpl_status_e'(rc_tdata[CPL_STATUS_LSB +: STATUS_WIDTH]);
  assign tag_hit    = rc_tvalid && rc_tready && (cpl_tag == TAG_WIDTH'(entry));
  assign last_entry = (entry == ROM_ADDR_WIDTH'(ROM_ENTRIES - 1));

  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      state     <= CFG_IDLE;
      entry     <= '0;
      cfg_done  <= 1'b0;
      cfg_error <= 1'b0;
    end else begin
      cfg_done  <= 1'b0;
      cfg_error <= 1'b0;
      case (state)
        CFG_IDLE: if (start_config) begin
          entry <= '0;
          state <= CFG_SEND;
        end
        CFG_SEND: if (cfg_rq_tready) state <= CFG_WAIT_CPL;
        CFG_WAIT_CPL: begin
          // Other tags are consumed and dropped
          if (tag_hit) begin
            if (cpl_status != CPL_SC) begin
              cfg_error <= 1'b1;
              state     <= CFG_IDLE;
            end else if (last_entry) begin
              cfg_done <= 1'b1;
              state    <= CFG_IDLE;
            end else begin
              entry <= entry + 1'b1;
              state <= CFG_SEND;
            end
          end
        end
        default: state <= CFG_IDLE;
      endcase
    end
  end

endmodule

// File: hw/link_controller.sv
`timescale 1ns/1ps

module link_controller
  import oculink_pkg::*;
(
  input  logic                  user_clk,
  input  logic                  user_reset,
  input  logic                  user_lnk_up,
  output logic                  start_config,
  input  logic                  cfg_done,
  input  logic                  cfg_error,
  input  logic                  ring_sq,
  input  logic [QPTR_WIDTH-1:0] sq_tail,
  input  logic                  ring_cq,
  input  logic [QPTR_WIDTH-1:0] cq_head,
  output logic                  write_sqtdbl,
  output logic [QPTR_WIDTH-1:0] sqt_value,
  output logic                  write_cqhdbl,
  output logic [QPTR_WIDTH-1:0] cqh_value,
  input  logic                  write_sqtdbl_done,
  input  logic                  write_cqhdbl_done,
  output logic                  port_ready,
  output logic                  cfg_fail
);

  localparam int SQ = 0;
  localparam int CQ = 1;

  ctl_state_e            state;
  logic [1:0]            ring_in;
  logic [1:0]            done_in;
  logic [1:0]            pend;     // Ring seen, not yet issued
  logic [1:0]            req;      // Write level towards doorbell
  logic [1:0]            issue;
  logic [QPTR_WIDTH-1:0] ring_val [2];
  logic [QPTR_WIDTH-1:0] pend_val [2];
  logic [QPTR_WIDTH-1:0] req_val  [2];

  assign port_ready = (state == CTL_READY);
  assign cfg_fail   = (state == CTL_FAILED);

  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      state        <= CTL_WAIT_LINK;
      start_config <= 1'b0;
    end else begin
      start_config <= 1'b0;
      case (state)
        CTL_WAIT_LINK: if (user_lnk_up) begin
          start_config <= 1'b1;
          state        <= CTL_CONFIG;
        end
        CTL_CONFIG: begin
          if (cfg_error)     state <= CTL_FAILED;  // Sticky until reset
          else if (cfg_done) state <= CTL_READY;
        end
        default: state <= state;
      endcase
    end
  end

  // --------------------
  // Doorbell requests
  // --------------------
  assign ring_in     = {ring_cq, ring_sq};
  assign done_in     = {write_cqhdbl_done, write_sqtdbl_done};
  assign ring_val[SQ] = sq_tail;
  assign ring_val[CQ] = cq_head;
  assign issue       = pend & ~req & {2{state == CTL_READY}};

  assign write_sqtdbl = req[SQ];
  assign sqt_value    = req_val[SQ];
  assign write_cqhdbl = req[CQ];
  assign cqh_value    = req_val[CQ];

  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      pend <= '0;
      req  <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (ring_in[i])    pend[i] <= 1'b1;  // A ring in the issue cycle stays pending
        else if (issue[i]) pend[i] <= 1'b0;
        if (issue[i])        req[i] <= 1'b1;
        else if (done_in[i]) req[i] <= 1'b0;
      end
    end
  end

  always_ff @(posedge user_clk) begin
    for (int i = 0; i < 2; i++) begin
      if (ring_in[i]) pend_val[i] <= ring_val[i];  // Latest ring wins
      if (issue[i])   req_val[i]  <= pend_val[i];  // Frozen for the write
    end
  end

endmodule

// File: hw/doorbell.sv
`timescale 1ns/1ps

module doorbell
  import oculink_pkg::*;
(
  input  logic                  user_clk,
  input  logic                  user_reset,
  input  logic                  write_sqtdbl,
  input  logic [QPTR_WIDTH-1:0] sqt_value,
  input  logic                  write_cqhdbl,
  input  logic [QPTR_WIDTH-1:0] cqh_value,
  output logic                  write_sqtdbl_done,
  output logic                  write_cqhdbl_done,
  output logic [DATA_WIDTH-1:0] db_rq_tdata,
  output logic                  db_rq_tvalid,
  input  logic                  db_rq_tready
);

  logic                   cq_sel;      // Doorbell in flight is the CQ one
  logic                   done_cycle;
  logic                   load_sq;
  logic                   load_cq;
  logic [ADDR_WIDTH-1:0]  db_addr;
  logic [DWORD_WIDTH-1:0] db_data;

  // Write level is still up during the done pulse
  assign done_cycle = write_sqtdbl_done || write_cqhdbl_done;
  assign load_sq    = !db_rq_tvalid && !done_cycle && write_sqtdbl;
  assign load_cq    = !db_rq_tvalid && !done_cycle && !write_sqtdbl && write_cqhdbl;

  assign db_addr = load_sq ? DB_BASE : DB_BASE + DB_STRIDE;
  assign db_data = DWORD_WIDTH'(load_sq ? sqt_value : cqh_value);

  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      db_rq_tvalid      <= 1'b0;
      cq_sel            <= 1'b0;
      write_sqtdbl_done <= 1'b0;
      write_cqhdbl_done <= 1'b0;
    end else begin
      if (load_sq || load_cq) begin
        db_rq_tvalid <= 1'b1;
        cq_sel       <= load_cq;
      end else if (db_rq_tready) begin
        db_rq_tvalid <= 1'b0;
      end
      write_sqtdbl_done <= db_rq_tvalid && db_rq_tready && !cq_sel;
      write_cqhdbl_done <= db_rq_tvalid && db_rq_tready && cq_sel;
    end
  end

  always_ff @(posedge user_clk) begin
    if (load_sq || load_cq) db_rq_tdata <= make_rq(REQ_MEM_WRITE, '0, db_addr, db_data);
  end

endmodule

// File: hw/rq_arbiter.sv
`timescale 1ns/1ps

module rq_arbiter
  import oculink_pkg::*;
(
  input  logic                  user_clk,
  input  logic                  user_reset,
  input  logic [DATA_WIDTH-1:0] cfg_rq_tdata,
  input  logic                  cfg_rq_tvalid,
  output logic                  cfg_rq_tready,
  input  logic [DATA_WIDTH-1:0] db_rq_tdata,
  input  logic                  db_rq_tvalid,
  output logic                  db_rq_tready,
  output logic [DATA_WIDTH-1:0] rq_tdata,
  output logic                  rq_tvalid,
  input  logic                  rq_tready
);

  logic load_en;

  // Output slot free, or its beat leaves this cycle
  assign load_en = !rq_tvalid || rq_tready;

  // --------------------
  // Fixed priority
  // --------------------
  assign cfg_rq_tready = load_en && cfg_rq_tvalid;
  assign db_rq_tready  = load_en && db_rq_tvalid && !cfg_rq_tvalid;

  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      rq_tvalid <= 1'b0;
    end else if (load_en) begin
      rq_tvalid <= cfg_rq_tvalid || db_rq_tvalid;
    end
  end

  always_ff @(posedge user_clk) begin
    if (cfg_rq_tready) begin
      rq_tdata <= cfg_rq_tdata;
    end else if (db_rq_tready) begin
      rq_tdata <= db_rq_tdata;
    end
  end

endmodule

// File: hw/oculink_host.sv
`timescale 1ns/1ps

module oculink_host
  import oculink_pkg::*;
#(
  parameter int ROM_ENTRIES    = 4,
  parameter int ROM_ADDR_WIDTH = 6
) (
  input  logic                  user_clk,
  input  logic                  user_reset,
  input  logic                  user_lnk_up,
  output logic [DATA_WIDTH-1:0] rq_tdata,
  output logic                  rq_tvalid,
  input  logic                  rq_tready,
  input  logic [DATA_WIDTH-1:0] rc_tdata,
  input  logic                  rc_tvalid,
  output logic                  rc_tready,
  input  logic                  ring_sq,
  input  logic [QPTR_WIDTH-1:0] sq_tail,
  input  logic                  ring_cq,
  input  logic [QPTR_WIDTH-1:0] cq_head,
  output logic                  port_ready,
  output logic                  cfg_fail
);

  // --------------------
  // Controller handshakes
  // --------------------
  logic                  start_config;
  logic                  cfg_done;
  logic                  cfg_error;
  logic                  write_sqtdbl;
  logic [QPTR_WIDTH-1:0] sqt_value;
  logic                  write_cqhdbl;
  logic [QPTR_WIDTH-1:0] cqh_value;
  logic                  write_sqtdbl_done;
  logic                  write_cqhdbl_done;

  // Config table lookup
  logic [ROM_ADDR_WIDTH-1:0] rom_addr;
  logic [CFG_OFF_WIDTH-1:0]  rom_offset;
  logic [DWORD_WIDTH-1:0]    rom_data;

  // --------------------
  // Request sources
  // --------------------
  logic [DATA_WIDTH-1:0] cfg_rq_tdata;
  logic                  cfg_rq_tvalid;
  logic                  cfg_rq_tready;
  logic [DATA_WIDTH-1:0] db_rq_tdata;
  logic                  db_rq_tvalid;
  logic                  db_rq_tready;

  link_controller ctl0 (.*);

  configurator #(
    .ROM_ENTRIES    (ROM_ENTRIES),
    .ROM_ADDR_WIDTH (ROM_ADDR_WIDTH)
  ) cfg0 (.*);

  config_rom #(
    .ROM_ENTRIES    (ROM_ENTRIES),
    .ROM_ADDR_WIDTH (ROM_ADDR_WIDTH)
  ) rom0 (.*);

  doorbell db0 (.*);

  rq_arbiter arb0 (.*);  // Configurator has priority

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  initial clk = 1'b0;
  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// File: test/oculink_host_props.sv
`timescale 1ns/1ps

module oculink_host_props
  import oculink_pkg::*;
(
  input logic                  user_clk,
  input logic                  user_reset,
  input logic [DATA_WIDTH-1:0] rq_tdata,
  input logic                  rq_tvalid,
  input logic                  rq_tready,
  input logic                  port_ready,
  input logic                  cfg_fail
);

  // Stalled beat keeps valid and payload
  a_rq_hold: assert property (
    @(posedge user_clk) disable iff (user_reset)
    (rq_tvalid && !rq_tready) |=> (rq_tvalid && $stable(rq_tdata))
  ) else $error("rq_tdata or rq_tvalid changed while the beat was stalled");

  a_status_sticky: assert property (
    @(posedge user_clk) disable iff (user_reset)
    (port_ready || cfg_fail) |=> $stable({port_ready, cfg_fail})  // Outcome holds until reset
  ) else $error("port_ready or cfg_fail changed after bring-up ended");

endmodule

bind oculink_host oculink_host_props props0 (
  .user_clk   (user_clk),
  .user_reset (user_reset),
  .rq_tdata   (rq_tdata),
  .rq_tvalid  (rq_tvalid),
  .rq_tready  (rq_tready),
  .port_ready (port_ready),
  .cfg_fail   (cfg_fail)
);

// File: test/oculink_host_tb.sv
`timescale 1ns/1ps

module oculink_host_tb
  import oculink_pkg::*;
();

  localparam int         CFG_ROWS        = 4;
  localparam int         RING_ROWS       = 6;
  localparam int         FAIL_ENTRY      = 2;
  localparam logic [7:0] STRAY_TAG       = 8'h55;
  localparam int         WATCHDOG_CYCLES = 300 * (2 * CFG_ROWS + RING_ROWS);

  // {offset, data} per config write, ROM order
  localparam logic [43:0] CFG_TABLE [CFG_ROWS] = '{
    {12'h010, 32'hF000_0000}, {12'h014, 32'h0000_0000},
    {12'h004, 32'h0000_0006}, {12'h03C, 32'h0000_01FF}
  };

  // {is_cq, pointer, doorbell address}
  localparam logic [48:0] RING_TABLE [RING_ROWS] = '{
    {1'b0, 16'h0001, 32'hF000_1000}, {1'b1, 16'h0001, 32'hF000_1004},
    {1'b0, 16'h00A5, 32'hF000_1000}, {1'b1, 16'h003F, 32'hF000_1004},
    {1'b0, 16'hFFFF, 32'hF000_1000}, {1'b1, 16'h8000, 32'hF000_1004}
  };

  logic                  user_clk;
  logic                  user_reset;
  logic                  user_lnk_up;
  logic [DATA_WIDTH-1:0] rq_tdata;
  logic                  rq_tvalid;
  logic                  rq_tready;
  logic [DATA_WIDTH-1:0] rc_tdata;
  logic                  rc_tvalid;
  logic                  rc_tready;
  logic                  ring_sq;
  logic [QPTR_WIDTH-1:0] sq_tail;
  logic                  ring_cq;
  logic [QPTR_WIDTH-1:0] cq_head;
  logic                  port_ready;
  logic                  cfg_fail;

  logic [31:0]           lcg_state;
  logic                  cpl_taken;   // Completion leaves at the next rising edge
  logic                  send_stray;
  cpl_status_e           run_status [CFG_ROWS];
  logic [DATA_WIDTH-1:0] beats [$];   // Requests seen on the bus
  logic [DATA_WIDTH-1:0] cpl_q [$];
  int                    value_errors;
  int                    other_errors;

  tb_clock #(.PERIOD_NS(40)) clk0 (.clk(user_clk));

  oculink_host dut0 (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic expect_equal(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    assert (got === exp) else begin
      value_errors++;
      $display("Error: %s is %h, expected %h", name, got, exp);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond) else begin
      other_errors++;
      $display("Failure: %s", what);
    end
  endtask

  // --------------------
  // Bus side
  // --------------------
  // Answers config writes, stray one first when enabled
  task automatic record_beat(input logic [DATA_WIDTH-1:0] beat);
    logic [7:0] tag;
    tag = beat[RQ_TAG_LSB +: 8];
    beats.push_back(beat);
    if (beat[RQ_TYPE_LSB +: 4] == REQ_CFG_WRITE0 && tag < 8'(CFG_ROWS)) begin
      if (send_stray && tag == 8'd1) cpl_q.push_back({85'd0, CPL_SC, STRAY_TAG, 32'd0});
      cpl_q.push_back({85'd0, run_status[tag[1:0]], tag, 32'd0});
    end
  endtask

  // Drive on the falling edge, then note what moves at the next rising edge
  task automatic tick();
    @(negedge user_clk);
    lcg_state = lcg_next(lcg_state);
    rq_tready = (lcg_state[31:30] != 2'b00);  // About one stall in four
    if (cpl_taken) rc_tvalid = 1'b0;
    if (!rc_tvalid && cpl_q.size() != 0) begin
      rc_tdata  = cpl_q.pop_front();
      rc_tvalid = 1'b1;
    end
    cpl_taken = rc_tvalid && rc_tready;
    if (rq_tvalid && rq_tready) record_beat(rq_tdata);
  endtask

  task automatic wait_beat(output logic [DATA_WIDTH-1:0] beat);
    while (beats.size() == 0) tick();
    beat = beats.pop_front();
  endtask

  task automatic check_beat(input logic [DATA_WIDTH-1:0] beat, input req_type_e rtype,
                            input logic [7:0] tag, input logic [63:0] addr,
                            input logic [31:0] data);
    expect_equal("rq_tdata type", 64'(beat[RQ_TYPE_LSB +: 4]), 64'(rtype));
    expect_equal("rq_tdata tag", 64'(beat[RQ_TAG_LSB +: 8]), 64'(tag));
    expect_equal("rq_tdata address", beat[RQ_ADDR_LSB +: 64], addr);
    expect_equal("rq_tdata data", 64'(beat[RQ_DATA_LSB +: 32]), 64'(data));
    expect_equal("rq_tdata reserved bits", 64'(beat[127:108]), 64'd0);
  endtask

  // --------------------
  // Sequences
  // --------------------
  task automatic apply_reset();
    user_reset  = 1'b1;
    user_lnk_up = 1'b0;
    rc_tvalid   = 1'b0;
    cpl_taken   = 1'b0;
    cpl_q.delete();
    repeat (4) tick();
    user_reset = 1'b0;
    beats.delete();
    repeat (10) begin  // Link still down
      tick();
      expect_equal("rq_tvalid", 64'(rq_tvalid), 64'd0);
      expect_equal("rc_tready", 64'(rc_tready), 64'd0);
      expect_equal("port_ready", 64'(port_ready), 64'd0);
      expect_equal("cfg_fail", 64'(cfg_fail), 64'd0);
    end
  endtask

  task automatic bring_up(input int last_entry);
    logic [DATA_WIDTH-1:0] beat;
    user_lnk_up = 1'b1;
    for (int i = 0; i <= last_entry; i++) begin
      wait_beat(beat);
      expect_true(!port_ready, "port_ready rose before the last config write");
      check_beat(beat, REQ_CFG_WRITE0, 8'(i), {32'd0, TARGET_ID, 4'd0, CFG_TABLE[i][43:32]},
                 CFG_TABLE[i][31:0]);
    end
  endtask

  task automatic ring_doorbell(input logic [48:0] row);
    ring_sq = !row[48];
    ring_cq = row[48];
    if (row[48]) cq_head = row[47:32];
    else sq_tail = row[47:32];
    tick();
    ring_sq = 1'b0;
    ring_cq = 1'b0;
  endtask

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge user_clk);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin : main
    logic [DATA_WIDTH-1:0] beat;
    user_reset   = 1'b1;
    user_lnk_up  = 1'b0;
    rq_tready    = 1'b0;
    rc_tdata     = '0;
    rc_tvalid    = 1'b0;
    ring_sq      = 1'b0;
    sq_tail      = '0;
    ring_cq      = 1'b0;
    cq_head      = '0;
    lcg_state    = 32'hf2ed_7431;
    cpl_taken    = 1'b0;
    value_errors = 0;
    other_errors = 0;

    // Clean bring-up with a stray completion ahead of entry 1
    send_stray = 1'b1;
    for (int i = 0; i < CFG_ROWS; i++) run_status[i] = CPL_SC;
    apply_reset();
    bring_up(CFG_ROWS - 1);
    while (!port_ready) tick();
    expect_true(cpl_q.size() == 0 && !rc_tvalid,
                "port_ready rose before the last completion was taken");
    expect_equal("cfg_fail", 64'(cfg_fail), 64'd0);
    expect_equal("rc_tready", 64'(rc_tready), 64'd0);
    expect_true(beats.size() == 0, "extra request after configuration");

    for (int i = 0; i < RING_ROWS; i++) begin
      ring_doorbell(RING_TABLE[i]);
      wait_beat(beat);
      check_beat(beat, REQ_MEM_WRITE, 8'd0, {32'd0, RING_TABLE[i][31:0]},
                 {16'd0, RING_TABLE[i][47:32]});
    end

    // Endpoint rejects entry 2
    send_stray = 1'b0;
    run_status[FAIL_ENTRY] = CPL_UR;
    apply_reset();
    bring_up(FAIL_ENTRY);
    while (!cfg_fail) tick();
    ring_doorbell(RING_TABLE[0]);
    repeat (40) tick();
    expect_equal("port_ready", 64'(port_ready), 64'd0);
    expect_equal("cfg_fail", 64'(cfg_fail), 64'd1);
    expect_true(beats.size() == 0, "request issued after a failed configuration");

    $display("Check summary: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: oculink_host.f
hw/oculink_pkg.sv
hw/config_rom.sv
hw/configurator.sv
hw/link_controller.sv
hw/doorbell.sv
hw/rq_arbiter.sv
hw/oculink_host.sv
test/tb_clock.sv
test/oculink_host_props.sv
test/oculink_host_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module oculink_host_tb -f oculink_host.f \
  -o oculink_host_sim > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/oculink_host_sim > sim.log 2>&1
grep -qx "ALL CHECKS PASSED" sim.log && echo "Simulation passed" || { echo "Simulation failed, see sim.log"; exit 1; }
